// File: verilog.f
logic/bus_unit_pkg.sv
logic/wb_bus_if.sv
logic/prefetch.sv
logic/memops.sv
logic/wb_priority_arb.sv
logic/bus_unit_top.sv
test/wb_mem_model.sv
test/bus_unit_tb.sv

// File: Makefile
# Verilator build and run for the bus unit testbench

TOP := bus_unit_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir $(LOG)

// File: test/bus_unit_tb.sv
// Testbench for the bus unit
// Plays the CPU on fetch and data ports, table rows applied in a loop
`timescale 1ns/1ps
`default_nettype none

module bus_unit_tb;

	localparam int NUM_ROWS = 20;
	localparam int STEP_LIMIT = 100;

	typedef enum logic [1:0] {K_FETCH, K_LOAD, K_STORE, K_PAIR} kind_t;

	// One stimulus row, unused fields zero
	typedef struct packed {
		kind_t                 kind;
		bus_unit_pkg::mem_op_t op;
		logic [31:0]           addr;
		logic [31:0]           data;
		logic [31:0]           pc;
		bus_unit_pkg::reg_id_t rd;
		logic [31:0]           result;
		logic                  err;
	} row_t;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_pf_new_pc;
	logic                  i_pf_ready;
	logic [31:0]           i_pf_pc;
	logic                  o_pf_valid;
	logic                  o_pf_illegal;
	bus_unit_pkg::word_t   o_pf_insn;
	logic [31:0]           o_pf_insn_pc;
	logic                  i_mem_stb;
	bus_unit_pkg::mem_op_t i_mem_op;
	logic [31:0]           i_mem_addr;
	bus_unit_pkg::word_t   i_mem_data;
	bus_unit_pkg::reg_id_t i_mem_reg;
	logic                  o_mem_busy;
	logic                  o_mem_valid;
	logic                  o_mem_err;
	bus_unit_pkg::reg_id_t o_mem_wreg;
	bus_unit_pkg::word_t   o_mem_result;
	// Shared Wishbone bus
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [29:0]           wb_addr;
	bus_unit_pkg::word_t   wb_data_w;
	bus_unit_pkg::sel_t    wb_sel;
	logic                  wb_stall;
	logic                  wb_ack;
	logic                  wb_err;
	bus_unit_pkg::word_t   wb_data_r;

	row_t rows [NUM_ROWS];
	int   total_checks;
	int   total_errors;
	int   row_errors;

	bus_unit_top #(
		.ADDRESS_WIDTH(30)
	) i_dut (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_pf_new_pc(i_pf_new_pc), .i_pf_ready(i_pf_ready), .i_pf_pc(i_pf_pc),
		.o_pf_valid(o_pf_valid), .o_pf_illegal(o_pf_illegal),
		.o_pf_insn(o_pf_insn), .o_pf_insn_pc(o_pf_insn_pc),
		.i_mem_stb(i_mem_stb), .i_mem_op(i_mem_op), .i_mem_addr(i_mem_addr),
		.i_mem_data(i_mem_data), .i_mem_reg(i_mem_reg),
		.o_mem_busy(o_mem_busy), .o_mem_valid(o_mem_valid), .o_mem_err(o_mem_err),
		.o_mem_wreg(o_mem_wreg), .o_mem_result(o_mem_result),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
		.o_wb_addr(wb_addr), .o_wb_data(wb_data_w), .o_wb_sel(wb_sel),
		.i_wb_stall(wb_stall), .i_wb_ack(wb_ack),
		.i_wb_err(wb_err), .i_wb_data(wb_data_r)
	);

	wb_mem_model #(
		.ADDRESS_WIDTH(30)
	) mem_model (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we),
		.i_addr(wb_addr), .i_data(wb_data_w), .i_sel(wb_sel),
		.o_stall(wb_stall), .o_ack(wb_ack), .o_err(wb_err), .o_data(wb_data_r)
	);

	// 20 ns period
	initial
	begin
		i_clk = 1'b0;
		forever
			#10 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	// Memory preset, word address XOR a constant
	function automatic logic [31:0] preset_word(input logic [31:0] byte_addr);
		return {2'b00, byte_addr[31:2]} ^ 32'h5a5a_0000;
	endfunction

	function automatic string kind_label(input kind_t k);
		case (k)
		K_FETCH: return "fetch";
		K_LOAD:  return "load";
		K_STORE: return "store";
		default: return "pair";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		total_checks++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual);
			row_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		total_checks++;
		assert (cond)
		else
		begin
			$display("ERROR at %0t ns: %s", $time, what);
			row_errors++;
		end
	endtask

	// Step on falling edges until an instruction is offered
	task automatic wait_fetch(output bit ok);
		int n;
		n = 0;
		while (!o_pf_valid && n < STEP_LIMIT)
		begin
			@(negedge i_clk);
			n++;
		end
		ok = o_pf_valid;
		check_true(ok, "timeout waiting for o_pf_valid");
	endtask

	//////////////////////////////////////////////////
	// Row runners
	//////////////////////////////////////////////////
	task automatic run_fetch(input row_t r);
		bit ok;
		logic [31:0] pc;
		i_pf_new_pc = 1'b1;
		i_pf_pc = r.pc;
		// Faulting fetch is held, not consumed
		i_pf_ready = !r.err;
		@(negedge i_clk);
		i_pf_new_pc = 1'b0;
		if (r.err)
		begin
			wait_fetch(ok);
			if (ok)
				check_value("o_pf_illegal", 32'd1, {31'd0, o_pf_illegal});
			return;
		end
		for (int k = 0; k < 3; k++)
		begin
			pc = r.pc + 32'(4 * k);
			wait_fetch(ok);
			if (!ok)
				return;
			check_value("o_pf_insn", preset_word(pc), o_pf_insn);
			check_value("o_pf_insn_pc", pc, o_pf_insn_pc);
			check_value("o_pf_illegal", 32'd0, {31'd0, o_pf_illegal});
			// Consumed on the rising edge in between
			@(negedge i_clk);
		end
		// Next word lands and holds, bus left idle
		i_pf_ready = 1'b0;
		wait_fetch(ok);
	endtask

	task automatic mem_access(input row_t r, output bit got_valid, output bit got_err,
		output logic [31:0] result, output bus_unit_pkg::reg_id_t wreg);
		int n;
		i_mem_stb = 1'b1;
		i_mem_op = r.op;
		i_mem_addr = r.addr;
		i_mem_data = r.data;
		i_mem_reg = r.rd;
		@(negedge i_clk);
		i_mem_stb = 1'b0;
		got_valid = 1'b0;
		got_err = 1'b0;
		result = '0;
		wreg = '0;
		n = 0;
		forever
		begin
			if (o_mem_valid)
			begin
				got_valid = 1'b1;
				result = o_mem_result;
				wreg = o_mem_wreg;
			end
			if (o_mem_err)
				got_err = 1'b1;
			if (!o_mem_busy)
				break;
			if (n == STEP_LIMIT)
			begin
				check_true(1'b0, "timeout waiting for the data access to finish");
				break;
			end
			n++;
			@(negedge i_clk);
		end
	endtask

	task automatic run_data(input row_t r);
		bit got_valid;
		bit got_err;
		logic [31:0] result;
		bus_unit_pkg::reg_id_t wreg;
		mem_access(r, got_valid, got_err, result, wreg);
		if (r.err)
		begin
			check_true(got_err, "expected o_mem_err did not come");
			check_true(!got_valid, "o_mem_valid pulsed on a failed access");
		end
		else
		begin
			check_true(!got_err, "unexpected o_mem_err");
			if (r.kind == K_LOAD)
			begin
				check_true(got_valid, "o_mem_valid did not pulse for the load");
				check_value("o_mem_result", r.result, result);
				check_value("o_mem_wreg", r.rd, wreg);
			end
			else
				check_true(!got_valid, "o_mem_valid pulsed for a store");
		end
	endtask

	// Load and fetch issued on the same edge
	task automatic run_pair(input row_t r);
		bit got_mem;
		bit got_pf;
		int n;
		i_pf_new_pc = 1'b1;
		i_pf_pc = r.pc;
		i_pf_ready = 1'b0;
		i_mem_stb = 1'b1;
		i_mem_op = r.op;
		i_mem_addr = r.addr;
		i_mem_data = r.data;
		i_mem_reg = r.rd;
		@(negedge i_clk);
		i_pf_new_pc = 1'b0;
		i_mem_stb = 1'b0;
		got_mem = 1'b0;
		got_pf = 1'b0;
		n = 0;
		while (!(got_mem && got_pf))
		begin
			if (o_mem_err)
				check_true(1'b0, "unexpected o_mem_err in the paired access");
			if (o_mem_valid)
			begin
				got_mem = 1'b1;
				check_value("o_mem_result", r.result, o_mem_result);
				check_value("o_mem_wreg", r.rd, o_mem_wreg);
			end
			if (o_pf_valid && !got_pf)
			begin
				got_pf = 1'b1;
				// Data unit owns the idle bus first
				check_true(got_mem, "instruction arrived before the data result");
				check_value("o_pf_insn", preset_word(r.pc), o_pf_insn);
				check_value("o_pf_insn_pc", r.pc, o_pf_insn_pc);
			end
			if (n == STEP_LIMIT)
			begin
				check_true(1'b0, "timeout waiting for the paired load and fetch");
				break;
			end
			n++;
			@(negedge i_clk);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////
	task automatic fill_table();
		// kind, op, addr, store data, fetch pc, rd, result, err
		rows[0] = '{K_FETCH, bus_unit_pkg::LW, 32'h0, 32'h0, 32'h100, 5'd0, 32'h0, 1'b0};
		rows[1] = '{K_STORE, bus_unit_pkg::SW, 32'h200, 32'h12345678, 32'h0, 5'd0, 32'h0, 1'b0};
		rows[2] = '{K_LOAD, bus_unit_pkg::LW, 32'h200, 32'h0, 32'h0, 5'd5, 32'h12345678, 1'b0};
		// Offset 1 is lane 2, offsets 2..3 are lanes 1..0
		rows[3] = '{K_STORE, bus_unit_pkg::SB, 32'h301, 32'hab, 32'h0, 5'd0, 32'h0, 1'b0};
		rows[4] = '{K_STORE, bus_unit_pkg::SH, 32'h302, 32'hbeef, 32'h0, 5'd0, 32'h0, 1'b0};
		rows[5] = '{K_LOAD, bus_unit_pkg::LW, 32'h300, 32'h0, 32'h0, 5'd7, 32'h5aabbeef, 1'b0};
		rows[6] = '{K_LOAD, bus_unit_pkg::LB, 32'h301, 32'h0, 32'h0, 5'd8, 32'hab, 1'b0};
		rows[7] = '{K_LOAD, bus_unit_pkg::LH, 32'h302, 32'h0, 32'h0, 5'd9, 32'hbeef, 1'b0};
		rows[8] = '{K_LOAD, bus_unit_pkg::LB, 32'h303, 32'h0, 32'h0, 5'd10, 32'hef, 1'b0};
		rows[9] = '{K_LOAD, bus_unit_pkg::LH, 32'h400, 32'h0, 32'h0, 5'd12, 32'h5a5a, 1'b0};
		// Error region and misaligned accesses
		rows[10] = '{K_LOAD, bus_unit_pkg::LW, 32'h80000040, 32'h0, 32'h0, 5'd1, 32'h0, 1'b1};
		rows[11] = '{K_STORE, bus_unit_pkg::SW, 32'h80000044, 32'h1, 32'h0, 5'd0, 32'h0, 1'b1};
		rows[12] = '{K_FETCH, bus_unit_pkg::LW, 32'h0, 32'h0, 32'h80000080, 5'd0, 32'h0, 1'b1};
		rows[13] = '{K_LOAD, bus_unit_pkg::LH, 32'h201, 32'h0, 32'h0, 5'd2, 32'h0, 1'b1};
		rows[14] = '{K_LOAD, bus_unit_pkg::LW, 32'h202, 32'h0, 32'h0, 5'd2, 32'h0, 1'b1};
		rows[15] = '{K_STORE, bus_unit_pkg::SW, 32'h206, 32'h5, 32'h0, 5'd0, 32'h0, 1'b1};
		// First pair follows a fetch, second one a load
		rows[16] = '{K_FETCH, bus_unit_pkg::LW, 32'h0, 32'h0, 32'h500, 5'd0, 32'h0, 1'b0};
		rows[17] = '{K_PAIR, bus_unit_pkg::LW, 32'h600, 32'h0, 32'h700, 5'd11, 32'h5a5a0180, 1'b0};
		rows[18] = '{K_LOAD, bus_unit_pkg::LB, 32'h600, 32'h0, 32'h0, 5'd4, 32'h5a, 1'b0};
		rows[19] = '{K_PAIR, bus_unit_pkg::LH, 32'h20a, 32'h0, 32'h104, 5'd13, 32'h82, 1'b0};
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		i_reset = 1'b1;
		i_pf_new_pc = 1'b0;
		i_pf_ready = 1'b0;
		i_pf_pc = '0;
		i_mem_stb = 1'b0;
		i_mem_op = bus_unit_pkg::LW;
		i_mem_addr = '0;
		i_mem_data = '0;
		i_mem_reg = '0;
		total_checks = 0;
		total_errors = 0;
		fill_table();
		repeat (10) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			row_errors = 0;
			case (rows[i].kind)
			K_FETCH: run_fetch(rows[i]);
			K_PAIR:  run_pair(rows[i]);
			default: run_data(rows[i]);
			endcase
			total_errors += row_errors;
			$display("row %0d %s addr %h pc %h: %s", i, kind_label(rows[i].kind),
				rows[i].addr, rows[i].pc, (row_errors == 0) ? "ok" : "errors");
		end
		$display("Summary: %0d rows, %0d checks, %0d errors",
			NUM_ROWS, total_checks, total_errors);
		if (total_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog, 200 cycles per row
	initial
	begin
		repeat (NUM_ROWS * 200) @(posedge i_clk);
		$display("Timeout: run did not finish within %0d cycles", NUM_ROWS * 200);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/wb_mem_model.sv
// Wishbone slave memory for the testbench
// Random stall, ack one cycle after acceptance, error region at the top address bit
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
	parameter int ADDRESS_WIDTH = 30
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_reset,
	input  wire logic                     i_cyc,
	input  wire logic                     i_stb,
	input  wire logic                     i_we,
	input  wire logic [ADDRESS_WIDTH-1:0] i_addr,
	input  wire bus_unit_pkg::word_t      i_data,
	input  wire bus_unit_pkg::sel_t       i_sel,
	output logic                          o_stall,
	output logic                          o_ack,
	output logic                          o_err,
	output bus_unit_pkg::word_t           o_data
);

	// Only written words are kept
	bus_unit_pkg::word_t mem [logic [ADDRESS_WIDTH-1:0]];
	bus_unit_pkg::word_t cur;

	// Unwritten words read as word address XOR the preset constant
	function automatic bus_unit_pkg::word_t read_word(input logic [ADDRESS_WIDTH-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return bus_unit_pkg::word_t'(a) ^ 32'h5a5a_0000;
	endfunction

	//////////////////////////////////////////////////
	// Random stall, about one cycle in three
	//////////////////////////////////////////////////
	initial
	begin
		void'($urandom(32'hdae4a6af));
		o_stall = 1'b0;
		forever
		begin
			@(posedge i_clk);
			o_stall <= ($urandom % 3) == 0;
		end
	end

	//////////////////////////////////////////////////
	// Request handling
	//////////////////////////////////////////////////
	always @(posedge i_clk)
	begin
		o_ack <= 1'b0;
		o_err <= 1'b0;
		if (!i_reset && i_cyc && i_stb && !o_stall)
		begin
			// Top word address bit selects the error region
			if (i_addr[ADDRESS_WIDTH-1])
				o_err <= 1'b1;
			else
			begin
				cur = read_word(i_addr);
				if (i_we)
				begin
					// Merge only the selected lanes
					for (int i = 0; i < bus_unit_pkg::SEL_WIDTH; i++)
						if (i_sel[i])
							cur[i*8 +: 8] = i_data[i*8 +: 8];
					mem[i_addr] = cur;
				end
				o_ack <= 1'b1;
				o_data <= cur;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/bus_unit_top.sv
// Bus unit top level
// Prefetch and memory unit sharing one Wishbone master port
`timescale 1ns/1ps
`default_nettype none

module bus_unit_top #(
	parameter int ADDRESS_WIDTH = 30
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_reset,
	// Fetch side
	input  wire logic                     i_pf_new_pc,
	input  wire logic                     i_pf_ready,
	input  wire logic [ADDRESS_WIDTH+1:0] i_pf_pc,
	output logic                          o_pf_valid,
	output logic                          o_pf_illegal,
	output bus_unit_pkg::word_t           o_pf_insn,
	output logic [ADDRESS_WIDTH+1:0]      o_pf_insn_pc,
	// Data side
	input  wire logic                     i_mem_stb,
	input  wire bus_unit_pkg::mem_op_t    i_mem_op,
	input  wire logic [ADDRESS_WIDTH+1:0] i_mem_addr,
	input  wire bus_unit_pkg::word_t      i_mem_data,
	input  wire bus_unit_pkg::reg_id_t    i_mem_reg,
	output logic                          o_mem_busy,
	output logic                          o_mem_valid,
	output logic                          o_mem_err,
	output bus_unit_pkg::reg_id_t         o_mem_wreg,
	output bus_unit_pkg::word_t           o_mem_result,
	// Wishbone master
	output logic                          o_wb_cyc,
	output logic                          o_wb_stb,
	output logic                          o_wb_we,
	output logic [ADDRESS_WIDTH-1:0]      o_wb_addr,
	output bus_unit_pkg::word_t           o_wb_data,
	output bus_unit_pkg::sel_t            o_wb_sel,
	input  wire logic                     i_wb_stall,
	input  wire logic                     i_wb_ack,
	input  wire logic                     i_wb_err,
	input  wire bus_unit_pkg::word_t      i_wb_data
);

	// Per-unit buses into the arbiter
	wb_bus_if #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) pf_bus ();
	wb_bus_if #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) mem_bus ();

	//////////////////////////////////////////////////
	// Fetch and data units
	//////////////////////////////////////////////////
	prefetch #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) pf (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_new_pc(i_pf_new_pc), .i_ready(i_pf_ready), .i_pc(i_pf_pc),
		.o_valid(o_pf_valid), .o_illegal(o_pf_illegal),
		.o_insn(o_pf_insn), .o_pc(o_pf_insn_pc),
		.bus(pf_bus)
	);

	memops #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) domem (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_stb(i_mem_stb), .i_op(i_mem_op), .i_addr(i_mem_addr),
		.i_data(i_mem_data), .i_reg(i_mem_reg),
		.o_busy(o_mem_busy), .o_valid(o_mem_valid), .o_err(o_mem_err),
		.o_wreg(o_mem_wreg), .o_result(o_mem_result),
		.bus(mem_bus)
	);

	//////////////////////////////////////////////////
	// Arbiter, data unit in the priority slot
	//////////////////////////////////////////////////
	wb_priority_arb #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) pformem (
		.i_clk(i_clk), .i_reset(i_reset),
		.a(mem_bus), .b(pf_bus),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
		.o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack),
		.i_wb_err(i_wb_err), .i_wb_data(i_wb_data)
	);

endmodule

`default_nettype wire

// File: logic/wb_priority_arb.sv
// Two-master Wishbone arbiter
// Data unit wins an idle bus, grant held until the owner drops cyc
`timescale 1ns/1ps
`default_nettype none

module wb_priority_arb #(
	parameter int ADDRESS_WIDTH = 30
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_reset,
	// Data unit, priority side
	wb_bus_if.slave                       a,
	// Prefetch
	wb_bus_if.slave                       b,
	// Shared bus
	output logic                          o_wb_cyc,
	output logic                          o_wb_stb,
	output logic                          o_wb_we,
	output logic [ADDRESS_WIDTH-1:0]      o_wb_addr,
	output bus_unit_pkg::word_t           o_wb_data,
	output bus_unit_pkg::sel_t            o_wb_sel,
	input  wire logic                     i_wb_stall,
	input  wire logic                     i_wb_ack,
	input  wire logic                     i_wb_err,
	input  wire bus_unit_pkg::word_t      i_wb_data
);

	// Last owner, set means the data unit
	logic r_owner_a;
	logic owner_cyc;
	logic grant_a;

	//////////////////////////////////////////////////
	// Grant
	//////////////////////////////////////////////////
	assign owner_cyc = r_owner_a ? a.cyc : b.cyc;

	// Moves only once the owner has let go
	always_comb
	begin
		if (owner_cyc)
			grant_a = r_owner_a;
		else if (a.cyc)
			grant_a = 1'b1;
		else if (b.cyc)
			grant_a = 1'b0;
		else
			// Idle bus falls back to the data unit
			grant_a = 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_owner_a <= 1'b1;
		else
			r_owner_a <= grant_a;
	end

	//////////////////////////////////////////////////
	// Routing
	//////////////////////////////////////////////////
	assign o_wb_cyc = grant_a ? a.cyc : b.cyc;
	assign o_wb_stb = grant_a ? a.stb : b.stb;
	assign o_wb_we = grant_a ? a.we : b.we;
	assign o_wb_addr = grant_a ? a.addr : b.addr;
	assign o_wb_data = grant_a ? a.data_w : b.data_w;
	assign o_wb_sel = grant_a ? a.sel : b.sel;

	// Loser always sees stall
	assign a.stall = !grant_a || i_wb_stall;
	assign b.stall = grant_a || i_wb_stall;

	// Responses to the owner only
	assign a.ack = grant_a && i_wb_ack;
	assign a.err = grant_a && i_wb_err;
	assign b.ack = !grant_a && i_wb_ack;
	assign b.err = !grant_a && i_wb_err;
	assign a.data_r = i_wb_data;
	assign b.data_r = i_wb_data;

	// Granted master keeps the bus as long as it holds cyc
	assert property (@(posedge i_clk) disable iff (i_reset)
		(grant_a && a.cyc) |=> (grant_a || !a.cyc));

	assert property (@(posedge i_clk) disable iff (i_reset)
		(!grant_a && b.cyc) |=> (!grant_a || !b.cyc));

endmodule

`default_nettype wire

// File: logic/memops.sv
// Load/store unit
// One access at a time, big-endian lane steering, zero-extended loads
`timescale 1ns/1ps
`default_nettype none

module memops #(
	parameter int ADDRESS_WIDTH = 30
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_reset,
	// Core side
	input  wire logic                     i_stb,
	input  wire bus_unit_pkg::mem_op_t    i_op,
	input  wire logic [ADDRESS_WIDTH+1:0] i_addr,
	input  wire bus_unit_pkg::word_t      i_data,
	input  wire bus_unit_pkg::reg_id_t    i_reg,
	output logic                          o_busy,
	output logic                          o_valid,
	output logic                          o_err,
	output bus_unit_pkg::reg_id_t         o_wreg,
	output bus_unit_pkg::word_t           o_result,
	// Bus side
	wb_bus_if.master                      bus
);

	localparam int DW = bus_unit_pkg::DATA_WIDTH;

	logic                  accept;
	logic                  misaligned;
	bus_unit_pkg::sel_t    w_sel;
	bus_unit_pkg::word_t   w_data;
	bus_unit_pkg::word_t   w_shifted;
	bus_unit_pkg::word_t   w_load;
	// Size and byte offset of the access in flight
	bus_unit_pkg::mem_op_t r_op;
	logic [1:0]            r_off;

	assign accept = i_stb && !o_busy;

	//////////////////////////////////////////////////
	// Store lanes and alignment
	//////////////////////////////////////////////////
	// Offset 0 lands in lane 3
	always_comb
	begin
		case (i_op)
		bus_unit_pkg::LH, bus_unit_pkg::SH:
		begin
			misaligned = i_addr[0];
			w_sel = 4'b1100 >> i_addr[1:0];
			w_data = {i_data[15:0], 16'h0} >> {i_addr[1:0], 3'b000};
		end
		bus_unit_pkg::LB, bus_unit_pkg::SB:
		begin
			misaligned = 1'b0;
			w_sel = 4'b1000 >> i_addr[1:0];
			w_data = {i_data[7:0], 24'h0} >> {i_addr[1:0], 3'b000};
		end
		default:
		begin
			misaligned = |i_addr[1:0];
			w_sel = '1;
			w_data = i_data;
		end
		endcase
	end

	//////////////////////////////////////////////////
	// Load extraction
	//////////////////////////////////////////////////
	// Move the addressed field to the top, then zero-extend
	assign w_shifted = bus.data_r << {r_off, 3'b000};

	always_comb
	begin
		case (r_op)
		bus_unit_pkg::LH:
			w_load = {{(DW-16){1'b0}}, w_shifted[DW-1:DW-16]};
		bus_unit_pkg::LB:
			w_load = {{(DW-8){1'b0}}, w_shifted[DW-1:DW-8]};
		default:
			w_load = bus.data_r;
		endcase
	end

	//////////////////////////////////////////////////
	// Access control
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		// Single clock pulses
		o_valid <= 1'b0;
		o_err <= 1'b0;
		if (i_reset)
		begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			bus.we <= 1'b0;
			o_busy <= 1'b0;
		end
		else if (o_busy)
		begin
			if (!bus.stall)
				bus.stb <= 1'b0;
			if (bus.ack || bus.err)
			begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
				o_busy <= 1'b0;
				// Stores finish quietly
				o_valid <= bus.ack && !bus.we;
				o_err <= bus.err;
			end
		end
		else if (accept)
		begin
			// Misaligned never reaches the bus
			if (misaligned)
				o_err <= 1'b1;
			else
			begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
				bus.we <= i_op[0];
				o_busy <= 1'b1;
			end
		end
	end

	// Request payload and result
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			bus.addr <= i_addr[ADDRESS_WIDTH+1:2];
			bus.data_w <= w_data;
			bus.sel <= w_sel;
			o_wreg <= i_reg;
			r_op <= i_op;
			r_off <= i_addr[1:0];
		end
		if (o_busy && bus.ack)
			o_result <= w_load;
	end

	// Busy only covers a live bus cycle
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_busy |-> bus.cyc);

	// Misaligned access errors out without a bus cycle
	assert property (@(posedge i_clk) disable iff (i_reset)
		(accept && misaligned) |=> (o_err && !bus.cyc));

endmodule

`default_nettype wire

// File: logic/prefetch.sv
// Instruction prefetch
// Fetches one word at a time and holds it until the core takes it
`timescale 1ns/1ps
`default_nettype none

module prefetch #(
	parameter int ADDRESS_WIDTH = 30
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_reset,
	// Core side
	input  wire logic                     i_new_pc,
	input  wire logic                     i_ready,
	input  wire logic [ADDRESS_WIDTH+1:0] i_pc,
	output logic                          o_valid,
	output logic                          o_illegal,
	output bus_unit_pkg::word_t           o_insn,
	output logic [ADDRESS_WIDTH+1:0]      o_pc,
	// Bus side
	wb_bus_if.master                      bus
);

	// Word address of the fetch in flight
	logic [ADDRESS_WIDTH-1:0] req_addr;
	// Abort done, fetch starts next clock
	logic restart;

	// Read only, whole word
	assign bus.we = 1'b0;
	assign bus.sel = '1;
	assign bus.data_w = '0;
	assign bus.addr = req_addr;

	//////////////////////////////////////////////////
	// Bus cycle control
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			restart <= 1'b0;
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
		end
		else if (i_new_pc)
		begin
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
			// Drop a cycle in flight, else start at once
			restart <= bus.cyc;
			bus.cyc <= !bus.cyc;
			bus.stb <= !bus.cyc;
		end
		else if (restart)
		begin
			restart <= 1'b0;
			bus.cyc <= 1'b1;
			bus.stb <= 1'b1;
		end
		else if (bus.cyc)
		begin
			if (!bus.stall)
				bus.stb <= 1'b0;
			// Word or error arrives
			if (bus.ack || bus.err)
			begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
				o_valid <= 1'b1;
				o_illegal <= bus.err;
			end
		end
		else if (o_valid && i_ready)
		begin
			o_valid <= 1'b0;
			// After a bus error wait for a new PC
			if (!o_illegal)
			begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Address and holding register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_new_pc)
			req_addr <= i_pc[ADDRESS_WIDTH+1:2];
		else if (!bus.cyc && !restart && o_valid && i_ready)
			req_addr <= req_addr + 1'b1;

		// Capture only while our own cycle is live
		if (!i_new_pc && bus.cyc && (bus.ack || bus.err))
		begin
			o_insn <= bus.data_r;
			o_pc <= {req_addr, 2'b00};
		end
	end

	// Held instruction blocks the next request
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && !i_ready && !i_new_pc) |=> !bus.stb);

endmodule

`default_nettype wire

// File: logic/wb_bus_if.sv
// Pipelined Wishbone bus with stall
// One master and one slave view
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if #(
	parameter int ADDRESS_WIDTH = 30
);

	// Request side
	logic                       cyc;
	logic                       stb;
	logic                       we;
	logic [ADDRESS_WIDTH-1:0]   addr;
	bus_unit_pkg::word_t        data_w;
	bus_unit_pkg::sel_t         sel;

	// Response side
	logic                       stall;
	logic                       ack;
	logic                       err;
	bus_unit_pkg::word_t        data_r;

	// Unit issuing requests
	modport master (
		output cyc, stb, we, addr, data_w, sel,
		input  stall, ack, err, data_r
	);

	// Arbiter receiving requests
	modport slave (
		input  cyc, stb, we, addr, data_w, sel,
		output stall, ack, err, data_r
	);

endinterface

`default_nettype wire

// File: logic/bus_unit_pkg.sv
// Bus unit shared definitions
// Word and lane widths, register numbers, memory operation codes
`default_nettype none

package bus_unit_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// One data or instruction word
	localparam int DATA_WIDTH = 32;

	// Byte lanes per word
	localparam int SEL_WIDTH = DATA_WIDTH / 8;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef logic [DATA_WIDTH-1:0] word_t;

	// Lane 3 is the most significant byte
	typedef logic [SEL_WIDTH-1:0] sel_t;

	// Destination register of a load
	typedef logic [4:0] reg_id_t;

	// Upper two bits give the size, low bit set for a store
	typedef enum logic [2:0]
	{
		LW = 3'b010,
		SW = 3'b011,
		LH = 3'b100,
		SH = 3'b101,
		LB = 3'b110,
		SB = 3'b111
	} mem_op_t;

endpackage

`default_nettype wire
